/* src/coherence_pkg.sv */
// two cores and 32-bit words only; data addresses must be word aligned for the snoop flags
package coherence_pkg;

    localparam int NUM_CORES     = 2;
    localparam int WORD_W        = 32;
    localparam int SNOOP_REQ_BIT = 0;
    localparam int SNOOP_INV_BIT = 1;

    // arbiter states
    localparam logic [1:0] ARB_IDLE   = 2'd0;
    localparam logic [1:0] ARB_SETTLE = 2'd1;
    localparam logic [1:0] ARB_BUSY   = 2'd2;

    // sequencer steps
    localparam logic [3:0] SEQ_WAIT_GRANT = 4'd0;
    localparam logic [3:0] SEQ_ACK        = 4'd1;
    localparam logic [3:0] SEQ_SNOOP      = 4'd2;
    localparam logic [3:0] SEQ_DECIDE     = 4'd3;
    localparam logic [3:0] SEQ_TRANSFER   = 4'd4;
    localparam logic [3:0] SEQ_INVALIDATE = 4'd5;
    localparam logic [3:0] SEQ_MEM_LOAD   = 4'd6;
    localparam logic [3:0] SEQ_WRITEBACK  = 4'd7;
    localparam logic [3:0] SEQ_FETCH      = 4'd8;
    localparam logic [3:0] SEQ_DONE       = 4'd9;

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [$clog2(NUM_CORES)-1:0] core_id_t;

    typedef enum logic [1:0]
    {
        FREE,
        BUSY,
        ACCESS,
        ERROR
    } ramstate_t;

    typedef enum logic [2:0]
    {
        NONE,
        WRITEBACK,
        READ_SHARED,
        READ_EXCL,
        IFETCH
    } req_kind_t;

    // snoop word, either a plain word or word address plus the two flags
    typedef union packed
    {
        word_t word;
        struct packed
        {
            logic [WORD_W-3:0] word_addr;
            logic              inv;
            logic              req;
        } fields;
    } snoop_word_u;

endpackage

/* src/bus_arbiter.sv */
`timescale 1ns/1ps
// grants one transaction at a time; requests must stay asserted until served
module bus_arbiter (
    input  logic                                CLK,
    input  logic                                nRST,
    input  logic [coherence_pkg::NUM_CORES-1:0] iren,
    input  logic [coherence_pkg::NUM_CORES-1:0] dren,
    input  logic [coherence_pkg::NUM_CORES-1:0] dwen,
    input  logic [coherence_pkg::NUM_CORES-1:0] ccwrite,
    input  logic [coherence_pkg::NUM_CORES-1:0] cctrans,
    input  logic                                txn_done,
    output coherence_pkg::req_kind_t            grant_kind,
    output coherence_pkg::core_id_t             grant_core
);
    import coherence_pkg::*;

    logic [1:0] state;
    req_kind_t  pick_kind;
    core_id_t   pick_core;

    // lowest class first, so later loops override earlier picks
    // descending core index lets core 0 win inside a class
    always_comb
    begin
        pick_kind = NONE;
        pick_core = '0;
        for (int c = NUM_CORES - 1; c >= 0; c--)
        begin
            if (iren[c])
            begin
                pick_kind = IFETCH;
                pick_core = core_id_t'(c);
            end
        end
        // data read only counts once the cache marks it in progress
        for (int c = NUM_CORES - 1; c >= 0; c--)
        begin
            if (dren[c] && cctrans[c])
            begin
                pick_kind = ccwrite[c] ? READ_EXCL : READ_SHARED;
                pick_core = core_id_t'(c);
            end
        end
        for (int c = NUM_CORES - 1; c >= 0; c--)
        begin
            if (dwen[c])
            begin
                pick_kind = WRITEBACK;
                pick_core = core_id_t'(c);
            end
        end
    end

    always_ff @(posedge CLK, negedge nRST)
    begin
        if (!nRST)
        begin
            state      <= ARB_IDLE;
            grant_kind <= NONE;
            grant_core <= '0;
        end
        else
        begin
            case (state)
                ARB_IDLE:
                begin
                    if (pick_kind != NONE)
                        state <= ARB_SETTLE;
                end
                ARB_SETTLE:
                begin
                    // requests get one cycle to settle before the pick is taken
                    grant_kind <= pick_kind;
                    grant_core <= pick_core;
                    state      <= (pick_kind != NONE) ? ARB_BUSY : ARB_IDLE;
                end
                ARB_BUSY:
                begin
                    if (txn_done)
                    begin
                        state      <= ARB_IDLE;
                        grant_kind <= NONE;
                    end
                end
                default:
                    state <= ARB_IDLE;
            endcase
        end
    end

endmodule

/* src/snoop_sequencer.sv */
`timescale 1ns/1ps
// serves the granted transaction only; a snooped cache that never drops cctrans stalls the bus
module snoop_sequencer (
    input  logic                                                   CLK,
    input  logic                                                   nRST,
    input  coherence_pkg::req_kind_t                               grant_kind,
    input  coherence_pkg::core_id_t                                grant_core,
    input  coherence_pkg::word_t [coherence_pkg::NUM_CORES-1:0]     iaddr,
    input  coherence_pkg::word_t [coherence_pkg::NUM_CORES-1:0]     daddr,
    input  coherence_pkg::word_t [coherence_pkg::NUM_CORES-1:0]     dstore,
    input  logic [coherence_pkg::NUM_CORES-1:0]                     ccwrite,
    input  logic [coherence_pkg::NUM_CORES-1:0]                     cctrans,
    input  logic                                                   ram_done,
    input  coherence_pkg::word_t                                   ramload,
    output logic [coherence_pkg::NUM_CORES-1:0]                     iwait,
    output logic [coherence_pkg::NUM_CORES-1:0]                     dwait,
    output coherence_pkg::word_t [coherence_pkg::NUM_CORES-1:0]     iload,
    output coherence_pkg::word_t [coherence_pkg::NUM_CORES-1:0]     dload,
    output logic [coherence_pkg::NUM_CORES-1:0]                     ccwait,
    output logic [coherence_pkg::NUM_CORES-1:0]                     ccinv,
    output coherence_pkg::snoop_word_u [coherence_pkg::NUM_CORES-1:0] ccsnoopaddr,
    output logic                                                   next_ren,
    output logic                                                   next_wen,
    output coherence_pkg::word_t                                   next_addr,
    output coherence_pkg::word_t                                   next_store,
    output logic                                                   txn_done
);
    import coherence_pkg::*;

    logic [3:0]                  step;
    logic [3:0]                  step_next;
    core_id_t                    req;
    core_id_t                    oth;
    snoop_word_u [NUM_CORES-1:0] snoop_next;

    assign req = grant_core;
    // two cores, so the other one is the inverted index
    assign oth = ~grant_core;

    always_ff @(posedge CLK, negedge nRST)
    begin
        if (!nRST)
        begin
            step        <= SEQ_WAIT_GRANT;
            ccsnoopaddr <= '0;
        end
        else
        begin
            step        <= step_next;
            ccsnoopaddr <= snoop_next;
        end
    end

    always_comb
    begin
        step_next = step;
        case (step)
            SEQ_WAIT_GRANT:
            begin
                if (grant_kind == IFETCH)
                    step_next = SEQ_FETCH;
                else if (grant_kind != NONE)
                    step_next = SEQ_ACK;
            end
            SEQ_ACK:
                step_next = (grant_kind == WRITEBACK) ? SEQ_WRITEBACK : SEQ_SNOOP;
            SEQ_SNOOP:
                step_next = SEQ_DECIDE;
            SEQ_DECIDE:
            begin
                // dirty line in the other cache wins over memory
                if (ccwrite[oth])
                    step_next = SEQ_TRANSFER;
                else if (grant_kind == READ_EXCL)
                    step_next = SEQ_INVALIDATE;
                else
                    step_next = SEQ_MEM_LOAD;
            end
            SEQ_TRANSFER:
            begin
                if (cctrans[oth] && ram_done)
                    step_next = SEQ_DONE;
            end
            SEQ_INVALIDATE:
            begin
                if (!cctrans[oth])
                    step_next = SEQ_MEM_LOAD;
            end
            SEQ_MEM_LOAD,
            SEQ_WRITEBACK,
            SEQ_FETCH:
            begin
                if (ram_done)
                    step_next = SEQ_DONE;
            end
            default:
                step_next = SEQ_WAIT_GRANT;
        endcase
    end

    always_comb
    begin
        iwait      = '1;
        dwait      = '1;
        iload      = '0;
        dload      = '0;
        ccwait     = '0;
        ccinv      = '0;
        snoop_next = '0;
        next_ren   = 1'b0;
        next_wen   = 1'b0;
        next_addr  = '0;
        next_store = '0;
        txn_done   = 1'b0;

        // other core stalls for the whole transaction
        if (step != SEQ_WAIT_GRANT)
            ccwait[oth] = 1'b1;

        case (step)
            SEQ_ACK:
                ccinv[req] = 1'b1;
            SEQ_SNOOP:
            begin
                snoop_next[oth].fields.word_addr = daddr[req][WORD_W-1:2];
                snoop_next[oth].word[SNOOP_REQ_BIT] = 1'b1;
            end
            SEQ_DECIDE:
                snoop_next[oth] = ccsnoopaddr[oth];
            SEQ_TRANSFER:
            begin
                snoop_next[oth] = ccsnoopaddr[oth];
                ccinv[oth] = (grant_kind == READ_EXCL);
                // other cache supplies the line, RAM is updated at its address
                if (cctrans[oth])
                begin
                    next_wen   = !ram_done;
                    next_addr  = daddr[oth];
                    next_store = dstore[oth];
                    dload[req] = dstore[oth];
                    dwait[req] = !ram_done;
                    dwait[oth] = !ram_done;
                end
            end
            SEQ_INVALIDATE:
            begin
                snoop_next[oth].fields.word_addr = ccsnoopaddr[oth].fields.word_addr;
                snoop_next[oth].word[SNOOP_INV_BIT] = 1'b1;
                ccinv[oth] = 1'b1;
            end
            SEQ_MEM_LOAD:
            begin
                snoop_next[oth] = ccsnoopaddr[oth];
                next_ren   = !ram_done;
                next_addr  = daddr[req];
                dload[req] = ramload;
                dwait[req] = !ram_done;
            end
            SEQ_WRITEBACK:
            begin
                next_wen   = !ram_done;
                next_addr  = daddr[req];
                next_store = dstore[req];
                dwait[req] = !ram_done;
            end
            SEQ_FETCH:
            begin
                // fetch also holds the requester's data side
                ccwait     = '1;
                next_ren   = !ram_done;
                next_addr  = iaddr[req];
                iload[req] = ramload;
                iwait[req] = !ram_done;
            end
            SEQ_DONE:
                txn_done = 1'b1;
            default:
            begin
            end
        endcase
    end

endmodule

/* src/ram_port.sv */
`timescale 1ns/1ps
// ramstate must leave ACCESS between accesses for ram_done to fire; ERROR is not handled
module ram_port (
    input  logic                     CLK,
    input  logic                     nRST,
    input  logic                     next_ren,
    input  logic                     next_wen,
    input  coherence_pkg::word_t     next_addr,
    input  coherence_pkg::word_t     next_store,
    input  coherence_pkg::ramstate_t ramstate,
    output logic                     ramren,
    output logic                     ramwen,
    output coherence_pkg::word_t     ramaddr,
    output coherence_pkg::word_t     ramstore,
    output logic                     ram_done
);
    import coherence_pkg::*;

    ramstate_t prev_state;

    // first ACCESS cycle after any other status
    assign ram_done = (ramstate == ACCESS) && (prev_state != ACCESS);

    always_ff @(posedge CLK, negedge nRST)
    begin
        if (!nRST)
        begin
            ramren     <= 1'b0;
            ramwen     <= 1'b0;
            prev_state <= FREE;
        end
        else
        begin
            ramren     <= next_ren;
            ramwen     <= next_wen;
            prev_state <= ramstate;
        end
    end

    always_ff @(posedge CLK)
    begin
        // writes are word aligned
        if (next_wen)
            ramaddr <= {next_addr[WORD_W-1:2], 2'b00};
        else
            ramaddr <= next_addr;
        ramstore <= next_store;
    end

endmodule

/* src/memory_control.sv */
`timescale 1ns/1ps
// two cores share one RAM port; caches hold requests until their wait line pulses low
module memory_control (
    input  logic                                                   CLK,
    input  logic                                                   nRST,
    input  logic [coherence_pkg::NUM_CORES-1:0]                     iren,
    input  coherence_pkg::word_t [coherence_pkg::NUM_CORES-1:0]     iaddr,
    input  logic [coherence_pkg::NUM_CORES-1:0]                     dren,
    input  logic [coherence_pkg::NUM_CORES-1:0]                     dwen,
    input  coherence_pkg::word_t [coherence_pkg::NUM_CORES-1:0]     daddr,
    input  coherence_pkg::word_t [coherence_pkg::NUM_CORES-1:0]     dstore,
    input  logic [coherence_pkg::NUM_CORES-1:0]                     ccwrite,
    input  logic [coherence_pkg::NUM_CORES-1:0]                     cctrans,
    output logic [coherence_pkg::NUM_CORES-1:0]                     iwait,
    output logic [coherence_pkg::NUM_CORES-1:0]                     dwait,
    output coherence_pkg::word_t [coherence_pkg::NUM_CORES-1:0]     iload,
    output coherence_pkg::word_t [coherence_pkg::NUM_CORES-1:0]     dload,
    output logic [coherence_pkg::NUM_CORES-1:0]                     ccwait,
    output logic [coherence_pkg::NUM_CORES-1:0]                     ccinv,
    output coherence_pkg::snoop_word_u [coherence_pkg::NUM_CORES-1:0] ccsnoopaddr,
    output logic                                                   ramren,
    output logic                                                   ramwen,
    output coherence_pkg::word_t                                   ramaddr,
    output coherence_pkg::word_t                                   ramstore,
    input  coherence_pkg::ramstate_t                               ramstate,
    input  coherence_pkg::word_t                                   ramload
);
    import coherence_pkg::*;

    req_kind_t grant_kind;
    core_id_t  grant_core;
    logic      txn_done;
    logic      next_ren;
    logic      next_wen;
    word_t     next_addr;
    word_t     next_store;
    logic      ram_done;

    // stage 1, request arbitration
    bus_arbiter i_bus_arbiter (
        .CLK        (CLK),
        .nRST       (nRST),
        .iren       (iren),
        .dren       (dren),
        .dwen       (dwen),
        .ccwrite    (ccwrite),
        .cctrans    (cctrans),
        .txn_done   (txn_done),
        .grant_kind (grant_kind),
        .grant_core (grant_core)
    );

    // stage 2, coherence steps
    snoop_sequencer i_snoop_sequencer (
        .CLK         (CLK),
        .nRST        (nRST),
        .grant_kind  (grant_kind),
        .grant_core  (grant_core),
        .iaddr       (iaddr),
        .daddr       (daddr),
        .dstore      (dstore),
        .ccwrite     (ccwrite),
        .cctrans     (cctrans),
        .ram_done    (ram_done),
        .ramload     (ramload),
        .iwait       (iwait),
        .dwait       (dwait),
        .iload       (iload),
        .dload       (dload),
        .ccwait      (ccwait),
        .ccinv       (ccinv),
        .ccsnoopaddr (ccsnoopaddr),
        .next_ren    (next_ren),
        .next_wen    (next_wen),
        .next_addr   (next_addr),
        .next_store  (next_store),
        .txn_done    (txn_done)
    );

    // stage 3, RAM command registers
    ram_port i_ram_port (
        .CLK        (CLK),
        .nRST       (nRST),
        .next_ren   (next_ren),
        .next_wen   (next_wen),
        .next_addr  (next_addr),
        .next_store (next_store),
        .ramstate   (ramstate),
        .ramren     (ramren),
        .ramwen     (ramwen),
        .ramaddr    (ramaddr),
        .ramstore   (ramstore),
        .ram_done   (ram_done)
    );

endmodule

/* bench/ram_model.sv */
`timescale 1ns/1ps
// 256 words at address bits 9:2 only; fixed busy time, then exactly one ACCESS cycle per request
module ram_model (
    input  logic                     CLK,
    input  logic                     nRST,
    input  logic                     ramren,
    input  logic                     ramwen,
    input  coherence_pkg::word_t     ramaddr,
    input  coherence_pkg::word_t     ramstore,
    output coherence_pkg::ramstate_t ramstate,
    output coherence_pkg::word_t     ramload
);
    import coherence_pkg::*;

    localparam int    RAM_BUSY_CYCLES = 3;
    localparam word_t FILL_KEY        = 32'h5a5a_0f0f;

    word_t mem [256];
    int    count;

    // each word holds its own byte address xor a key
    initial
    begin
        for (int i = 0; i < 256; i++)
            mem[i] = word_t'(i << 2) ^ FILL_KEY;
    end

    assign ramload = mem[ramaddr[9:2]];

    always @(posedge CLK, negedge nRST)
    begin
        if (!nRST)
        begin
            ramstate <= FREE;
            count    <= 0;
        end
        else
        begin
            case (ramstate)
                FREE:
                begin
                    if (ramren || ramwen)
                    begin
                        ramstate <= BUSY;
                        count    <= RAM_BUSY_CYCLES - 1;
                    end
                end
                BUSY:
                begin
                    if (count == 0)
                    begin
                        ramstate <= ACCESS;
                        // write lands as ACCESS begins
                        if (ramwen)
                            mem[ramaddr[9:2]] <= ramstore;
                    end
                    else
                        count <= count - 1;
                end
                default:
                    ramstate <= FREE;
            endcase
        end
    end

endmodule

/* bench/memory_control_chk.sv */
`timescale 1ns/1ps
// bound into memory_control; reads the sequencer step through the bind connection
module memory_control_chk (
    input logic                                CLK,
    input logic                                nRST,
    input logic                                ramren,
    input logic                                ramwen,
    input logic [coherence_pkg::NUM_CORES-1:0] iwait,
    input logic [coherence_pkg::NUM_CORES-1:0] dwait,
    input logic [coherence_pkg::NUM_CORES-1:0] ccinv,
    input logic [3:0]                          step
);
    import coherence_pkg::*;

    a_one_ram_cmd: assert property (@(posedge CLK) disable iff (!nRST) !(ramren && ramwen))
        else $error("ramren and ramwen high in the same cycle");

    // invalidate of both caches only while the other cache is being served
    a_inv_both: assert property (@(posedge CLK) disable iff (!nRST)
        (&ccinv) |-> (step == SEQ_TRANSFER || step == SEQ_INVALIDATE))
        else $error("ccinv high to both cores outside transfer and invalidate");

    a_reset_waits: assert property (@(posedge CLK) !nRST |-> (&iwait && &dwait))
        else $error("iwait or dwait low during reset");

endmodule

bind memory_control memory_control_chk i_memory_control_chk (
    .CLK    (CLK),
    .nRST   (nRST),
    .ramren (ramren),
    .ramwen (ramwen),
    .iwait  (iwait),
    .dwait  (dwait),
    .ccinv  (ccinv),
    .step   (i_snoop_sequencer.step)
);

/* bench/memory_control_tb.sv */
`timescale 1ns/1ps
// rows run one at a time; FILL_KEY must match the preload key of ram_model
module memory_control_tb;
    import coherence_pkg::*;

    localparam int    NUM_ROWS = 9;
    localparam int    TIMEOUT  = 200;
    localparam word_t FILL_KEY = 32'h5a5a_0f0f;

    logic                        CLK;
    logic                        nRST;
    logic [NUM_CORES-1:0]        iren;
    logic [NUM_CORES-1:0]        dren;
    logic [NUM_CORES-1:0]        dwen;
    logic [NUM_CORES-1:0]        ccwrite;
    logic [NUM_CORES-1:0]        req_trans;
    logic [NUM_CORES-1:0]        snoop_trans;
    logic [NUM_CORES-1:0]        cctrans;
    word_t [NUM_CORES-1:0]       iaddr;
    word_t [NUM_CORES-1:0]       daddr;
    word_t [NUM_CORES-1:0]       dstore;
    logic [NUM_CORES-1:0]        iwait;
    logic [NUM_CORES-1:0]        dwait;
    logic [NUM_CORES-1:0]        ccwait;
    logic [NUM_CORES-1:0]        ccinv;
    logic [NUM_CORES-1:0]        ccinv_prev;
    word_t [NUM_CORES-1:0]       iload;
    word_t [NUM_CORES-1:0]       dload;
    snoop_word_u [NUM_CORES-1:0] ccsnoopaddr;
    logic                        ramren;
    logic                        ramwen;
    word_t                       ramaddr;
    word_t                       ramstore;
    word_t                       ramload;
    ramstate_t                   ramstate;

    // stimulus table with store data from the LFSR
    int        row_core  [NUM_ROWS];
    req_kind_t row_kind  [NUM_ROWS];
    word_t     row_addr  [NUM_ROWS];
    word_t     row_store [NUM_ROWS];
    logic      row_dirty [NUM_ROWS];
    word_t     row_odata [NUM_ROWS];
    logic      row_pair  [NUM_ROWS];

    word_t       exp_mem [256];
    logic [31:0] lfsr_state;
    int          row_idx;
    int          served_row;

    assign cctrans = req_trans | snoop_trans;

    memory_control i_memory_control (
        .CLK(CLK), .nRST(nRST), .iren(iren), .iaddr(iaddr), .dren(dren), .dwen(dwen),
        .daddr(daddr), .dstore(dstore), .ccwrite(ccwrite), .cctrans(cctrans),
        .iwait(iwait), .dwait(dwait), .iload(iload), .dload(dload), .ccwait(ccwait),
        .ccinv(ccinv), .ccsnoopaddr(ccsnoopaddr), .ramren(ramren), .ramwen(ramwen),
        .ramaddr(ramaddr), .ramstore(ramstore), .ramstate(ramstate), .ramload(ramload)
    );

    ram_model i_ram_model (
        .CLK(CLK), .nRST(nRST), .ramren(ramren), .ramwen(ramwen), .ramaddr(ramaddr),
        .ramstore(ramstore), .ramstate(ramstate), .ramload(ramload)
    );

    initial CLK = 1'b0;
    always #5 CLK = ~CLK;

    // snooped cache stand-in that supplies a dirty line once per row
    always @(posedge CLK)
    begin
        ccinv_prev <= ccinv;
        for (int c = 0; c < NUM_CORES; c++)
        begin
            if (snoop_trans[c] && (!dwait[c] || (ccinv_prev[c] && !ccinv[c])))
                snoop_trans[c] <= 1'b0;
            else if (row_idx < NUM_ROWS && served_row != row_idx && c != row_core[row_idx]
                     && row_dirty[row_idx] && ccsnoopaddr[c].fields.req)
            begin
                snoop_trans[c] <= 1'b1;
                served_row     <= row_idx;
            end
        end
    end

    function automatic word_t fill_word(input word_t addr);
        return {addr[31:2], 2'b00} ^ FILL_KEY;
    endfunction

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_word(output word_t w);
        for (int b = 0; b < 32; b++)
        begin
            lfsr_state = lfsr_step(lfsr_state);
            w[b] = lfsr_state[0];
        end
    endtask

    task automatic check_value(input string name, input word_t got, input word_t exp);
        if (got !== exp)
        begin
            $display("FAIL %s got %h expected %h", name, got, exp);
            $display("Test failed");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    task automatic give_up(input string what);
        $display("timeout, %s never arrived", what);
        $display("Test failed");
        $fatal(1, "wait timed out");
    endtask

    task automatic set_row(input int r, input int core, input req_kind_t kind,
                           input word_t addr, input logic dirty, input logic pair);
        row_core[r]  = core;
        row_kind[r]  = kind;
        row_addr[r]  = addr;
        row_dirty[r] = dirty;
        row_pair[r]  = pair;
        draw_word(row_store[r]);
        draw_word(row_odata[r]);
    endtask

    task automatic run_row(input int r);
        int                   c;
        int                   o;
        logic                 done;
        logic                 snoop_seen;
        logic                 inv_seen;
        logic [NUM_CORES-1:0] exp_wait;
        req_kind_t            kind;
        word_t                addr;
        c          = row_core[r];
        o          = 1 - c;
        kind       = row_kind[r];
        addr       = row_addr[r];
        done       = 1'b0;
        snoop_seen = 1'b0;
        inv_seen   = 1'b0;
        // the other core stalls, and a fetch stalls both cores
        exp_wait    = '0;
        exp_wait[o] = 1'b1;
        if (kind == IFETCH)
            exp_wait = '1;
        row_idx    = r;
        @(posedge CLK);
        ccwrite[o] <= row_dirty[r];
        if (kind == IFETCH)
        begin
            iren[c]  <= 1'b1;
            iaddr[c] <= addr;
        end
        else if (kind == WRITEBACK)
        begin
            dwen[c]   <= 1'b1;
            daddr[c]  <= addr;
            dstore[c] <= row_store[r];
        end
        else
        begin
            dren[c]      <= 1'b1;
            req_trans[c] <= 1'b1;
            ccwrite[c]   <= (kind == READ_EXCL);
            daddr[c]     <= addr;
            daddr[o]     <= addr;
            dstore[o]    <= row_odata[r];
        end
        for (int cyc = 0; cyc < TIMEOUT && !done; cyc++)
        begin
            @(negedge CLK);
            if (kind == IFETCH && !iwait[c])
            begin
                done = 1'b1;
                check_value("iload", iload[c], exp_mem[addr[9:2]]);
            end
            else if (kind != IFETCH && !dwait[c])
            begin
                done = 1'b1;
                if (kind == WRITEBACK)
                begin
                    check_value("ram word", i_ram_model.mem[addr[9:2]], row_store[r]);
                    exp_mem[addr[9:2]] = row_store[r];
                end
                else
                begin
                    if (row_dirty[r])
                    begin
                        check_value("dload", dload[c], row_odata[r]);
                        check_value("ram word", i_ram_model.mem[addr[9:2]], row_odata[r]);
                        exp_mem[addr[9:2]] = row_odata[r];
                    end
                    else
                        check_value("dload", dload[c], exp_mem[addr[9:2]]);
                    check_value("ccsnoopaddr request seen", snoop_seen, 1);
                    if (kind == READ_EXCL)
                        check_value("ccinv to other core seen", inv_seen, 1);
                end
            end
            if (done)
                check_value("ccwait", ccwait, exp_wait);
            if (ccsnoopaddr[o].word == {addr[31:2], 2'b01})
                snoop_seen = 1'b1;
            if (ccinv[o])
                inv_seen = 1'b1;
        end
        if (!done)
            give_up(kind == IFETCH ? "iwait low" : "dwait low");
        @(posedge CLK);
        iren      <= '0;
        dren      <= '0;
        dwen      <= '0;
        req_trans <= '0;
        ccwrite   <= '0;
        // done step and the arbiter's return to idle
        repeat (2) @(posedge CLK);
    endtask

    // writeback from core 1 and fetch from core 0 start together
    task automatic run_priority(input int r);
        int    n_d;
        int    n_i;
        int    quiet;
        logic  fetch_first;
        logic  drop_d;
        logic  drop_i;
        word_t fetch_addr;
        n_d         = 0;
        n_i         = 0;
        quiet       = 0;
        fetch_first = 1'b0;
        fetch_addr  = row_addr[r] + 32'h40;
        row_idx     = r;
        @(posedge CLK);
        dwen[1]   <= 1'b1;
        daddr[1]  <= row_addr[r];
        dstore[1] <= row_store[r];
        iren[0]   <= 1'b1;
        iaddr[0]  <= fetch_addr;
        for (int cyc = 0; cyc < TIMEOUT && quiet < 8; cyc++)
        begin
            @(negedge CLK);
            drop_d = !dwait[1];
            drop_i = !iwait[0];
            if (drop_d)
            begin
                n_d++;
                check_value("ram word", i_ram_model.mem[row_addr[r][9:2]], row_store[r]);
                exp_mem[row_addr[r][9:2]] = row_store[r];
            end
            if (drop_i)
            begin
                if (n_d == 0)
                    fetch_first = 1'b1;
                n_i++;
                check_value("iload[0]", iload[0], exp_mem[fetch_addr[9:2]]);
            end
            if (n_d > 0 && n_i > 0)
                quiet++;
            @(posedge CLK);
            if (drop_d)
                dwen[1] <= 1'b0;
            if (drop_i)
                iren[0] <= 1'b0;
        end
        if (n_d == 0 || n_i == 0)
            give_up("dwait[1] and iwait[0] low");
        check_value("dwait[1] pulses", n_d, 1);
        check_value("iwait[0] pulses", n_i, 1);
        check_value("fetch served before writeback", fetch_first, 0);
    endtask

    initial
    begin
        nRST        = 1'b0;
        iren        = '0;
        dren        = '0;
        dwen        = '0;
        ccwrite     = '0;
        req_trans   = '0;
        snoop_trans = '0;
        ccinv_prev  = '0;
        iaddr       = '0;
        daddr       = '0;
        dstore      = '0;
        lfsr_state  = 32'hde71_117d;
        row_idx     = NUM_ROWS;
        served_row  = -1;
        for (int i = 0; i < 256; i++)
            exp_mem[i] = fill_word(word_t'(i << 2));
        set_row(0, 0, IFETCH, 32'h040, 1'b0, 1'b0);
        set_row(1, 1, WRITEBACK, 32'h080, 1'b0, 1'b0);
        set_row(2, 0, IFETCH, 32'h080, 1'b0, 1'b0);
        set_row(3, 0, READ_SHARED, 32'h0c0, 1'b0, 1'b0);
        set_row(4, 1, READ_SHARED, 32'h100, 1'b1, 1'b0);
        set_row(5, 0, READ_EXCL, 32'h140, 1'b0, 1'b0);
        set_row(6, 1, READ_EXCL, 32'h180, 1'b1, 1'b0);
        set_row(7, 1, WRITEBACK, 32'h1c0, 1'b0, 1'b1);
        set_row(8, 1, IFETCH, 32'h100, 1'b0, 1'b0);
        repeat (8) @(posedge CLK);
        nRST <= 1'b1;
        for (int r = 0; r < NUM_ROWS; r++)
        begin
            if (row_pair[r])
                run_priority(r);
            else
                run_row(r);
        end
        $display("Test completed successfully");
        $finish;
    end

endmodule

/* sources.f */
src/coherence_pkg.sv
src/bus_arbiter.sv
src/snoop_sequencer.sv
src/ram_port.sv
src/memory_control.sv
bench/ram_model.sv
bench/memory_control_chk.sv
bench/memory_control_tb.sv
